// File: compile.f
+incdir+include
design/fft_stream_pkg.sv
design/tone_result_pkg.sv
design/bin_magnitude.sv
design/spectral_peak_finder.sv
design/band_energy_accumulator.sv
design/tone_decider.sv
design/tone_detector_top.sv
verif/tone_detector_assertions.sv
verif/tone_detector_tb.sv

// File: Makefile
# Verilator build and run for the tone detector

VERILATOR  ?= verilator
TOP        ?= tone_detector_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_MSG   ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tone_detector_tb.sv
`timescale 1ns/1ps

`include "tone_macros.svh"

module tone_detector_tb;

    import fft_stream_pkg::*;
    import tone_result_pkg::*;

    localparam int N              = `TONE_NSAMPLES;
    localparam int NBITS          = $clog2(`TONE_NSAMPLES);
    localparam int RESET_CYCLES   = 16;
    localparam int NFRAMES        = 8;
    localparam int EXP_LATENCY    = 3;
    localparam int MAX_WAIT       = 8;
    localparam int TIMEOUT_CYCLES = NFRAMES * (N + 8) + RESET_CYCLES;

    // one row per frame where -1 marks an unused bin or abort position
    typedef struct packed {
        int tone_k;
        int tone_amp;
        int twin_k;
        int noise_amp;
        int spur_amp;
        int abort_pos;
    } frame_cfg_t;

    string names [NFRAMES] = '{"strong_tone", "noise_only", "dc_and_upper_spurs",
        "equal_twins", "aborted_then_full", "all_zero", "edge_bin_1", "weak_tone_in_noise"};

    frame_cfg_t cfg_tbl [NFRAMES] = '{
        '{5,  20000, -1, 50,   0,     -1},
        '{0,  0,     -1, 3000, 0,     -1},
        '{9,  2000,  -1, 100,  30000, -1},
        '{3,  10000, 12, 80,   0,     -1},
        '{7,  15000, -1, 200,  0,     17},
        '{0,  0,     -1, 0,    0,     -1},
        '{1,  12000, -1, 500,  0,     -1},
        '{31, 1500,  -1, 1200, 0,     -1}
    };

    logic         clk;
    logic         reset;
    sample_t      sample;
    logic         sample_valid;
    tone_result_t result;
    logic         result_valid;

    // frame contents indexed by natural bin
    int           re_v [N];
    int           im_v [N];
    longint       exp_peak;
    int           exp_k;
    longint       exp_energy;
    logic         exp_det;
    int           stray_results;
    int           test_errors;
    int           pass_count;
    int           fail_count;
    int           cycles = 0;

    tone_detector_top u_tone_detector_top (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped at the cycle limit of %0d before all frames finished",
                     TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic int bit_reverse(input int v);
        int r;
        r = 0;
        for (int j = 0; j < NBITS; j++) begin
            r[NBITS-1-j] = v[j];
        end
        return r;
    endfunction

    // uniform value in -amp .. amp
    function automatic int noise_val(input int amp);
        int span;
        if (amp == 0) begin
            return 0;
        end
        span = 2 * amp + 1;
        return int'($urandom % span) - amp;
    endfunction

    task automatic build_frame(input frame_cfg_t cfg);
        for (int k = 0; k < N; k++) begin
            re_v[k] = noise_val(cfg.noise_amp);
            im_v[k] = noise_val(cfg.noise_amp);
        end
        if (cfg.tone_amp != 0) begin
            re_v[cfg.tone_k] = cfg.tone_amp;
            im_v[cfg.tone_k] = -(cfg.tone_amp / 2);
            if (cfg.twin_k >= 0) begin
                re_v[cfg.twin_k] = cfg.tone_amp;
                im_v[cfg.twin_k] = -(cfg.tone_amp / 2);
            end
        end
        // spurs in DC and in the mirrored half lie outside the band
        if (cfg.spur_amp != 0) begin
            re_v[0]       = cfg.spur_amp;
            im_v[0]       = cfg.spur_amp;
            re_v[N/2 + 3] = cfg.spur_amp;
            im_v[N/2 + 3] = cfg.spur_amp;
            re_v[N - 1]   = cfg.spur_amp;
            im_v[N - 1]   = cfg.spur_amp;
        end
    endtask

    // walk the bins in arrival order so strict greater keeps the first of equal peaks
    task automatic compute_expected();
        int     k;
        longint m;
        exp_peak   = 0;
        exp_k      = 0;
        exp_energy = 0;
        for (int b = 0; b < N; b++) begin
            k = bit_reverse(b);
            m = longint'(re_v[k]) * re_v[k] + longint'(im_v[k]) * im_v[k];
            if (k != 0 && k < N / 2) begin
                exp_energy += m;
                if (m > exp_peak) begin
                    exp_peak = m;
                    exp_k    = k;
                end
            end
        end
        exp_det = ((exp_peak << `TONE_RATIO_SHIFT) > (exp_energy - exp_peak));
    endtask

    task automatic drive_beat(input int re, input int im, input logic valid);
        @(negedge clk);
        if (result_valid) begin
            stray_results++;
        end
        sample.re    = re[`TONE_SAMPLE_W-1:0];
        sample.im    = im[`TONE_SAMPLE_W-1:0];
        sample_valid = valid;
    endtask

    // latency counts falling edges after the final beat was driven
    task automatic wait_result(output int latency, output bit seen);
        latency = 0;
        seen    = 1'b0;
        while (!seen && latency < MAX_WAIT) begin
            @(negedge clk);
            sample       = '0;
            sample_valid = 1'b0;
            latency++;
            seen = result_valid;
        end
    endtask

    initial begin
        int latency;
        bit seen;
        reset        = 1'b1;
        sample       = '0;
        sample_valid = 1'b0;
        pass_count   = 0;
        fail_count   = 0;
        void'($urandom(32'hf1d4_acf2));
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < NFRAMES; i++) begin
            test_errors   = 0;
            stray_results = 0;
            build_frame(cfg_tbl[i]);
            compute_expected();
            if (cfg_tbl[i].abort_pos >= 0) begin
                // full-scale partial frame followed by a single idle cycle
                for (int b = 0; b <= cfg_tbl[i].abort_pos; b++) begin
                    drive_beat(32000, -32000, 1'b1);
                end
                drive_beat(0, 0, 1'b0);
            end
            for (int b = 0; b < N; b++) begin
                drive_beat(re_v[bit_reverse(b)], im_v[bit_reverse(b)], 1'b1);
            end
            wait_result(latency, seen);

            if (stray_results != 0) begin
                $display("%s: result_valid pulsed %0d times while the frame was streaming",
                         names[i], stray_results);
                test_errors++;
            end
            if (!seen) begin
                $display("%s: no result_valid within %0d cycles of the final beat",
                         names[i], MAX_WAIT);
                test_errors++;
            end else begin
                if (latency != EXP_LATENCY) begin
                    $display("ERR %s latency expected %0d actual %0d",
                             names[i], EXP_LATENCY, latency);
                    test_errors++;
                end
                if (result.peak != mag_t'(exp_peak)) begin
                    $display("ERR %s peak expected %0d actual %0d",
                             names[i], exp_peak, result.peak);
                    test_errors++;
                end
                if (result.peak_k != bin_idx_t'(exp_k)) begin
                    $display("ERR %s peak_k expected %0d actual %0d",
                             names[i], exp_k, result.peak_k);
                    test_errors++;
                end
                if (result.energy != energy_t'(exp_energy)) begin
                    $display("ERR %s energy expected %0d actual %0d",
                             names[i], exp_energy, result.energy);
                    test_errors++;
                end
                if (result.detected != exp_det) begin
                    $display("ERR %s detected expected %0d actual %0d",
                             names[i], exp_det, result.detected);
                    test_errors++;
                end
            end

            if (test_errors == 0) begin
                pass_count++;
                $display("test %s ok", names[i]);
            end else begin
                fail_count++;
                $display("test %s failed with %0d errors", names[i], test_errors);
            end
        end

        $display("tests %0d, passed %0d, failed %0d", NFRAMES, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/tone_detector_assertions.sv
`timescale 1ns/1ps

module tone_detector_assertions (
    input logic                          clk,
    input logic                          reset,
    input tone_result_pkg::tone_result_t result,
    input logic                          result_valid
);

    import fft_stream_pkg::*;
    import tone_result_pkg::*;

    localparam int KBITS = $bits(bin_idx_t);

    // one result per frame, never two cycles in a row
    a_single_pulse: assert property (
        @(posedge clk) disable iff (reset) result_valid |=> !result_valid
    ) else $error("result_valid stayed high for more than one cycle");

    // reset forces the output strobe low on the next edge
    a_quiet_in_reset: assert property (
        @(posedge clk) reset |=> !result_valid
    ) else $error("result_valid high while reset was asserted");

    // a nonzero peak can only come from the usable band
    a_peak_in_band: assert property (
        @(posedge clk) disable iff (reset)
        (result_valid && result.peak != '0) |->
            (result.peak_k != '0 && !result.peak_k[KBITS-1])
    ) else $error("peak_k %0d lies outside the usable band", result.peak_k);

    a_detect_needs_peak: assert property (
        @(posedge clk) disable iff (reset)
        (result_valid && result.detected) |-> (result.peak != '0)
    ) else $error("tone flagged with a zero peak");

endmodule

bind tone_detector_top tone_detector_assertions u_tone_detector_assertions (
    .clk          (clk),
    .reset        (reset),
    .result       (result),
    .result_valid (result_valid)
);

// File: design/tone_detector_top.sv
`timescale 1ns/1ps

module tone_detector_top (
    input  logic                          clk,
    input  logic                          reset,
    input  fft_stream_pkg::sample_t       sample,
    input  logic                          sample_valid,
    output tone_result_pkg::tone_result_t result,
    output logic                          result_valid
);

    import fft_stream_pkg::*;
    import tone_result_pkg::*;

    bin_mag_t bin;
    logic     bin_valid;
    mag_t     peak;
    bin_idx_t peak_k;
    logic     peak_valid;
    energy_t  energy;

    bin_magnitude u_bin_magnitude (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .bin          (bin),
        .bin_valid    (bin_valid)
    );

    spectral_peak_finder u_spectral_peak_finder (
        .clk        (clk),
        .reset      (reset),
        .bin        (bin),
        .bin_valid  (bin_valid),
        .peak       (peak),
        .peak_k     (peak_k),
        .peak_valid (peak_valid)
    );

    // energy_valid matches peak_valid cycle for cycle, the decider keys on peak_valid
    band_energy_accumulator u_band_energy_accumulator (
        .clk          (clk),
        .reset        (reset),
        .bin          (bin),
        .bin_valid    (bin_valid),
        .energy       (energy),
        .energy_valid ()
    );

    tone_decider u_tone_decider (
        .clk          (clk),
        .reset        (reset),
        .peak         (peak),
        .peak_k       (peak_k),
        .peak_valid   (peak_valid),
        .energy       (energy),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: design/tone_decider.sv
`timescale 1ns/1ps

`include "tone_macros.svh"

module tone_decider (
    input  logic                          clk,
    input  logic                          reset,
    input  fft_stream_pkg::mag_t          peak,
    input  fft_stream_pkg::bin_idx_t      peak_k,
    input  logic                          peak_valid,
    input  tone_result_pkg::energy_t      energy,
    output tone_result_pkg::tone_result_t result,
    output logic                          result_valid
);

    import tone_result_pkg::*;

    energy_t residual;
    energy_t peak_scaled;
    logic    detected;

    // peak is always part of the band energy, so no underflow here
    always_comb begin
        residual    = energy - energy_t'(peak);
        peak_scaled = energy_t'(peak) << `TONE_RATIO_SHIFT;
        detected    = peak_scaled > residual;
    end

    // energy_valid arrives together with peak_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= peak_valid;
            if (peak_valid) begin
                result.peak     <= peak;
                result.peak_k   <= peak_k;
                result.energy   <= energy;
                result.detected <= detected;
            end
        end
    end

endmodule

// File: design/band_energy_accumulator.sv
`timescale 1ns/1ps

module band_energy_accumulator (
    input  logic                      clk,
    input  logic                      reset,
    input  fft_stream_pkg::bin_mag_t  bin,
    input  logic                      bin_valid,
    output tone_result_pkg::energy_t  energy,
    output logic                      energy_valid
);

    import tone_result_pkg::*;

    energy_t acc;
    energy_t addend;
    energy_t acc_next;

    // out-of-band bins contribute nothing
    always_comb begin
        addend   = bin.in_band ? energy_t'(bin.mag) : '0;
        acc_next = acc + addend;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc          <= '0;
            energy       <= '0;
            energy_valid <= 1'b0;
        end else begin
            energy_valid <= bin_valid && bin.last;
            if (!bin_valid) begin
                acc <= '0;
            end else if (bin.last) begin
                energy <= acc_next;
                acc    <= '0;
            end else begin
                acc <= acc_next;
            end
        end
    end

endmodule

// File: design/spectral_peak_finder.sv
`timescale 1ns/1ps

module spectral_peak_finder (
    input  logic                     clk,
    input  logic                     reset,
    input  fft_stream_pkg::bin_mag_t bin,
    input  logic                     bin_valid,
    output fft_stream_pkg::mag_t     peak,
    output fft_stream_pkg::bin_idx_t peak_k,
    output logic                     peak_valid
);

    import fft_stream_pkg::*;

    mag_t     run_peak;
    bin_idx_t run_k;
    logic     take;

    // strictly greater, so ties keep the earlier bin
    always_comb begin
        take = bin.in_band && (bin.mag > run_peak);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_peak   <= '0;
            run_k      <= '0;
            peak       <= '0;
            peak_k     <= '0;
            peak_valid <= 1'b0;
        end else begin
            peak_valid <= bin_valid && bin.last;
            if (!bin_valid) begin
                // aborted frame
                run_peak <= '0;
                run_k    <= '0;
            end else if (bin.last) begin
                // publish including the last beat
                if (take) begin
                    peak   <= bin.mag;
                    peak_k <= bin.k;
                end else begin
                    peak   <= run_peak;
                    peak_k <= run_k;
                end
                run_peak <= '0;
                run_k    <= '0;
            end else if (take) begin
                run_peak <= bin.mag;
                run_k    <= bin.k;
            end
        end
    end

endmodule

// File: design/bin_magnitude.sv
`timescale 1ns/1ps

`include "tone_macros.svh"

module bin_magnitude (
    input  logic                    clk,
    input  logic                    reset,
    input  fft_stream_pkg::sample_t sample,
    input  logic                    sample_valid,
    output fft_stream_pkg::bin_mag_t bin,
    output logic                    bin_valid
);

    import fft_stream_pkg::*;

    localparam int NBITS = $bits(bin_idx_t);

    logic signed [2*`TONE_SAMPLE_W-1:0] re_sq;
    logic signed [2*`TONE_SAMPLE_W-1:0] im_sq;
    mag_t                               mag_next;
    bin_idx_t                           pos;
    bin_idx_t                           k_next;

    // both squares are non-negative, so zero extension is safe
    always_comb begin
        re_sq    = sample.re * sample.re;
        im_sq    = sample.im * sample.im;
        mag_next = mag_t'($unsigned(re_sq)) + mag_t'($unsigned(im_sq));
    end

    // FFT output arrives bit-reversed
    always_comb begin
        for (int j = 0; j < NBITS; j++) begin
            k_next[j] = pos[NBITS-1-j];
        end
    end

    // frame position, a gap in the stream restarts the frame
    always_ff @(posedge clk) begin
        if (reset) begin
            pos       <= '0;
            bin_valid <= 1'b0;
        end else begin
            bin_valid <= sample_valid;
            if (sample_valid) begin
                pos <= pos + 1'b1;
            end else begin
                pos <= '0;
            end
        end
    end

    // usable band is 1 .. N/2-1
    always_ff @(posedge clk) begin
        bin.mag     <= mag_next;
        bin.k       <= k_next;
        bin.in_band <= (k_next != '0) && !k_next[NBITS-1];
        bin.last    <= (pos == bin_idx_t'(`TONE_NSAMPLES - 1));
    end

endmodule

// File: design/tone_result_pkg.sv
`include "tone_macros.svh"

package tone_result_pkg;

    import fft_stream_pkg::*;

    // room for a full frame of maximum magnitudes
    typedef logic [$bits(mag_t)+$clog2(`TONE_NSAMPLES)-1:0] energy_t;

    typedef struct packed {
        mag_t     peak;
        bin_idx_t peak_k;
        energy_t  energy;
        logic     detected;
    } tone_result_t;

endpackage

// File: design/fft_stream_pkg.sv
`include "tone_macros.svh"

package fft_stream_pkg;

    // one complex FFT bin as delivered by the FFT core
    typedef struct packed {
        logic signed [`TONE_SAMPLE_W-1:0] re;
        logic signed [`TONE_SAMPLE_W-1:0] im;
    } sample_t;

    // re^2 + im^2 needs one bit more than the product width
    typedef logic [2*`TONE_SAMPLE_W:0] mag_t;

    // natural bin index
    typedef logic [$clog2(`TONE_NSAMPLES)-1:0] bin_idx_t;

    typedef struct packed {
        mag_t     mag;
        bin_idx_t k;
        logic     in_band;
        logic     last;
    } bin_mag_t;

endpackage

// File: include/tone_macros.svh
`ifndef TONE_MACROS_SVH
`define TONE_MACROS_SVH

// bins per FFT frame, must be a power of two
`define TONE_NSAMPLES 64

// width of the real and imaginary parts
`define TONE_SAMPLE_W 16

// tone when peak * 2^shift exceeds the rest of the band energy
`define TONE_RATIO_SHIFT 3

`endif
